// File: run_sim.sh
#!/usr/bin/env bash
# build the sigmoid testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module sigmoid_tb \
  -f vlog.f \
  -o sigmoid_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sigmoid_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
echo "pass line not found"
exit 1

// File: source/ap_start_control.sv
// start logic between the input stream and the core
// tracks whether the core is accepting, applies back-pressure and
// output-gap stalls, drives in_ready and the core start
`include "sigmoid_defs.svh"

module ap_start_control
  import sig_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  logic       out_ready,
  input  logic       hold_full,
  input  logic       waiting,
  input  ap_status_t status,
  output logic       in_ready,
  output ap_ctrl_t   ctrl
);

  logic idle_prev;
  logic done_prev;
  logic out_ready_prev;
  logic accepting;
  logic present_now;
  logic in_flight;
  logic delay;

  //##########################################################################
  // previous-cycle view of the core
  //##########################################################################

  // idle counts as dropped in the cycle of a start
  always_ff @(posedge clk) begin
    if (rst) begin
      idle_prev      <= 1'b0;
      done_prev      <= 1'b0;
      out_ready_prev <= 1'b0;
    end else begin
      idle_prev      <= status.idle & ~ctrl.start;
      done_prev      <= status.done;
      out_ready_prev <= out_ready;
    end
  end

  //##########################################################################
  // when a result is presented
  //##########################################################################

  generate
    if (`SIG_FORCE_LATENCY > 0) begin : g_forced
      localparam int LAT_W = $clog2(`SIG_FORCE_LATENCY + 1);
      logic [LAT_W-1:0] lat_count;

      // counts down from the forced latency, 1 marks the result cycle
      always_ff @(posedge clk) begin
        if (rst) begin
          lat_count <= '0;
        end else if (ctrl.start) begin
          lat_count <= LAT_W'(`SIG_FORCE_LATENCY);
        end else if (lat_count != '0) begin
          lat_count <= lat_count - 1'b1;
        end
      end

      assign present_now = (lat_count == LAT_W'(1));
      // no new start until the pending result is out
      assign in_flight   = (lat_count != '0);
    end else begin : g_done
      assign present_now = status.done & ~status.idle;
      assign in_flight   = 1'b0;
    end
  endgenerate

  //##########################################################################
  // ready and start
  //##########################################################################

  // idle last cycle, or done last cycle with the result taken
  assign accepting = (idle_prev | (done_prev & out_ready_prev)) & ~in_flight;

  // stall on a blocked output or during the post-output gap
  assign delay = (hold_full & ~out_ready)
               | (present_now & ~out_ready)
               | waiting;

  assign in_ready   = accepting & ~delay;
  // one input beat is one core start
  assign ctrl.start = in_valid & in_ready;

  // no start in any of the gap cycles that follow a presented result
  generate
    for (genvar k = 1; k <= `SIG_OUTPUT_GAP; k = k + 1) begin : g_gap_check
      a_no_start_in_gap: assert property (@(posedge clk) disable iff (rst)
        ctrl.start |-> !$past(present_now, k))
        else $error("start during the output gap");
    end
  endgenerate

endmodule

// File: source/output_gap_timer.sv
// post-output wait timer
// after each result, holds waiting high for the configured gap
`include "sigmoid_defs.svh"

module output_gap_timer
  import sig_ctrl_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic result_present,
  output logic waiting
);

  generate
    if (`SIG_OUTPUT_GAP > 0) begin : g_gap
      gap_state_t state;
      // cycles of waiting left after this one
      gap_count_t count;

      always_ff @(posedge clk) begin
        if (rst) begin
          state <= gap_open;
          count <= '0;
        end else begin
          case (state)
            gap_open: begin
              // load on each result
              if (result_present) begin
                state <= gap_waiting;
                count <= gap_count_t'(`SIG_OUTPUT_GAP - 1);
              end
            end
            gap_waiting: begin
              if (count == '0) begin
                state <= gap_open;
              end else begin
                count <= count - 1'b1;
              end
            end
            default: state <= gap_open;
          endcase
        end
      end

      assign waiting = (state == gap_waiting);
    end else begin : g_no_gap
      // no gap configured
      assign waiting = 1'b0;
    end
  endgenerate

endmodule

// File: source/output_hold_buffer.sv
// single-entry holding buffer on the output side
// captures a result the consumer refused and drives out_valid/out_data
// until the beat transfers
module output_hold_buffer
  import sig_fixed_pkg::*;
  import sig_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   result_present,
  input  fixed_t layer_data,
  input  logic   out_ready,
  output logic   hold_full,
  output logic   out_valid,
  output fixed_t out_data
);

  hold_state_t state;
  // captured sample
  fixed_t      hold_data;
  logic        capture;

  // result on the output this cycle but not taken
  assign capture = (state == hold_idle) & result_present & ~out_ready;

  //##########################################################################
  // holding FSM
  //##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= hold_idle;
    end else begin
      case (state)
        hold_idle: begin
          if (capture) begin
            state <= sig_ctrl_pkg::hold_full;
          end
        end
        sig_ctrl_pkg::hold_full: begin
          // drained on the first ready
          if (out_ready) begin
            state <= hold_idle;
          end
        end
        default: state <= hold_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      hold_data <= layer_data;
    end
  end

  //##########################################################################
  // output side
  //##########################################################################

  assign hold_full = (state == sig_ctrl_pkg::hold_full);
  assign out_valid = result_present | hold_full;
  // held sample wins while the buffer is full
  assign out_data  = hold_full ? hold_data : layer_data;

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output changed under back-pressure");

endmodule

// File: source/result_timing.sv
// per-cycle result strobe for the output side
// either done with idle low, or each start delayed by the forced latency
`include "sigmoid_defs.svh"

module result_timing
  import sig_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ap_ctrl_t   ctrl,
  input  ap_status_t status,
  output logic       result_present
);

  generate
    if (`SIG_FORCE_LATENCY > 0) begin : g_forced
      // one slot per cycle of latency, start enters at the top
      logic [`SIG_FORCE_LATENCY-1:0] start_line;

      always_ff @(posedge clk) begin
        if (rst) begin
          start_line <= '0;
        end else begin
          start_line                         <= start_line >> 1;
          start_line[`SIG_FORCE_LATENCY-1] <= ctrl.start;
        end
      end

      assign result_present = start_line[0];
    end else begin : g_done
      // core output cycle
      assign result_present = status.done & ~status.idle;
    end
  endgenerate

  // a forced latency shorter than the core would present stale data
  a_latency_range: assert property (@(posedge clk) disable iff (rst)
    (`SIG_FORCE_LATENCY <= 0) || (`SIG_FORCE_LATENCY >= `SIG_LAYER_DEPTH))
    else $error("forced latency below the core depth");

endmodule

// File: source/sig_ctrl_pkg.sv
// control types for the sigmoid wrapper
// start/done/idle structs, FSM state enums, gap counter type
`include "sigmoid_defs.svh"

package sig_ctrl_pkg;

  //##########################################################################
  // core control protocol
  //##########################################################################

  // wrapper to core
  typedef struct packed {
    logic start;
  } ap_ctrl_t;

  // core to wrapper
  typedef struct packed {
    logic done;
    logic idle;
    // core can take a start this cycle
    logic ready;
  } ap_status_t;

  //##########################################################################
  // state machines
  //##########################################################################

  // output holding buffer
  typedef enum logic {hold_idle, hold_full} hold_state_t;

  // post-output wait
  typedef enum logic {gap_open, gap_waiting} gap_state_t;

  // wide enough for the gap length, never zero bits
  localparam int GAP_CNT_W = (`SIG_OUTPUT_GAP > 0) ? $clog2(`SIG_OUTPUT_GAP + 1) : 1;
  typedef logic [GAP_CNT_W-1:0] gap_count_t;

endpackage

// File: source/sig_fixed_pkg.sv
// fixed-point sample type for the sigmoid datapath
// saturation limits and the one-half offset of the hard sigmoid
`include "sigmoid_defs.svh"

package sig_fixed_pkg;

  //##########################################################################
  // sample format
  //##########################################################################

  // one signed sample, 6 integer and 10 fraction bits
  typedef logic signed [`SIG_DATA_W-1:0] fixed_t;

  //##########################################################################
  // constants of the clamp rule
  //##########################################################################

  // lower saturation limit
  localparam fixed_t SIG_ZERO = '0;
  // upper saturation limit, 1.0
  localparam fixed_t SIG_ONE = fixed_t'(1 << `SIG_FRAC_W);
  // offset added after the shift, 0.5
  localparam fixed_t SIG_HALF = fixed_t'(1 << (`SIG_FRAC_W - 1));

endpackage

// File: source/sigmoid_defs.svh
// build-time constants for the sigmoid stream wrapper
// sample format, core pipeline depth, optional timing knobs
`ifndef SIGMOID_DEFS_SVH
`define SIGMOID_DEFS_SVH

// sample format Q6.10
`define SIG_DATA_W 16
`define SIG_FRAC_W 10

// cycles from an accepted start to done in the core
`define SIG_LAYER_DEPTH 2

// result strobe this many cycles after start
// zero or less falls back to the core's done
`define SIG_FORCE_LATENCY 0

// cycles that starts stay blocked after each result
`define SIG_OUTPUT_GAP 2

`endif

// File: source/sigmoid_layer.sv
// hard-sigmoid core with a start/done/idle control interface
// stage one shifts by two and adds one half, stage two clamps to [0, 1]
// valid pipe produces done and idle
`include "sigmoid_defs.svh"

module sigmoid_layer
  import sig_fixed_pkg::*;
  import sig_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ap_ctrl_t   ctrl,
  input  fixed_t     in_data,
  output ap_status_t status,
  output fixed_t     result
);

  // one bit per pipeline stage
  logic [1:0] vld_pipe;
  // x/4 + 0.5 before clamping
  fixed_t     stage1_q;
  fixed_t     clamp_d;

  //##########################################################################
  // control
  //##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[0], ctrl.start};
    end
  end

  always_comb begin
    status.done  = vld_pipe[1];
    // busy while any stage holds a sample
    status.idle  = ~|vld_pipe;
    status.ready = ~|vld_pipe | vld_pipe[1];
  end

  //##########################################################################
  // datapath
  //##########################################################################

  // stage one, arithmetic shift keeps the sign
  always_ff @(posedge clk) begin
    if (ctrl.start) begin
      stage1_q <= (in_data >>> 2) + SIG_HALF;
    end
  end

  // saturate to the output range
  always_comb begin
    if (stage1_q < SIG_ZERO) begin
      clamp_d = SIG_ZERO;
    end else if (stage1_q > SIG_ONE) begin
      clamp_d = SIG_ONE;
    end else begin
      clamp_d = stage1_q;
    end
  end

  // stage two, result held until the next sample arrives
  always_ff @(posedge clk) begin
    if (vld_pipe[0]) begin
      result <= clamp_d;
    end
  end

  // every done traces back to a start one pipeline depth earlier
  a_done_has_start: assert property (@(posedge clk) disable iff (rst)
    status.done |-> $past(ctrl.start, `SIG_LAYER_DEPTH))
    else $error("done without a matching start");

  // the wrapper only starts the core when it can take a sample
  a_start_when_ready: assert property (@(posedge clk) disable iff (rst)
    ctrl.start |-> status.ready)
    else $error("start while the core is busy");

endmodule

// File: source/sigmoid_top.sv
// top level of the sigmoid stream wrapper
// valid/ready in and out around the hard-sigmoid core
// start control, result strobe, output buffer and gap timer
module sigmoid_top
  import sig_fixed_pkg::*;
  import sig_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   in_valid,
  input  fixed_t in_data,
  output logic   in_ready,
  output logic   out_valid,
  output fixed_t out_data,
  input  logic   out_ready
);

  ap_ctrl_t   ctrl;
  ap_status_t status;
  fixed_t     layer_data;
  logic       result_present;
  logic       hold_full;
  logic       waiting;

  //##########################################################################
  // input side and core
  //##########################################################################

  ap_start_control u_start_control (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .hold_full (hold_full),
    .waiting   (waiting),
    .status    (status),
    .in_ready  (in_ready),
    .ctrl      (ctrl)
  );

  sigmoid_layer u_layer (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .in_data (in_data),
    .status  (status),
    .result  (layer_data)
  );

  //##########################################################################
  // output side
  //##########################################################################

  result_timing u_result_timing (
    .clk            (clk),
    .rst            (rst),
    .ctrl           (ctrl),
    .status         (status),
    .result_present (result_present)
  );

  output_hold_buffer u_hold_buffer (
    .clk            (clk),
    .rst            (rst),
    .result_present (result_present),
    .layer_data     (layer_data),
    .out_ready      (out_ready),
    .hold_full      (hold_full),
    .out_valid      (out_valid),
    .out_data       (out_data)
  );

  output_gap_timer u_gap_timer (
    .clk            (clk),
    .rst            (rst),
    .result_present (result_present),
    .waiting        (waiting)
  );

endmodule

// File: verif/sigmoid_tb_ref.svh
// reference model and compare tasks for the sigmoid testbench
// hard sigmoid from the clamp rule, typed compares for values and counts
`ifndef SIGMOID_TB_REF_SVH
`define SIGMOID_TB_REF_SVH

`include "sigmoid_defs.svh"

//############################################################################
// reference model
//############################################################################

// x/4 + 0.5, clamped to [0, 1], all in Q6.10
function automatic fixed_t ref_sigmoid(input fixed_t x);
  int one;
  int half;
  int v;
  one  = 1 << `SIG_FRAC_W;
  half = one / 2;
  // arithmetic shift on a signed int keeps the sign
  v = (int'(x) >>> 2) + half;
  if (v < 0) begin
    v = 0;
  end else if (v > one) begin
    v = one;
  end
  return fixed_t'(v);
endfunction

//############################################################################
// compare tasks
//############################################################################

// one output sample against its expected value
task automatic check_value(input fixed_t got, input fixed_t expected, input string what);
  if (got !== expected) begin
    value_errors++;
    $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
  end
endtask

// beat and queue counts at the end of the run
task automatic check_count(input int got, input int expected, input string what);
  if (got != expected) begin
    count_errors++;
    $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
  end
endtask

`endif

// File: verif/sigmoid_tb.sv
// testbench for the sigmoid stream wrapper
// clock, reset, DUT, stimulus drivers, scoreboard and timeout
// fixed sweep then random samples, random in_valid gaps and out_ready
`include "sigmoid_defs.svh"

module sigmoid_tb
  import sig_fixed_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_SWEEP     = 9;
  localparam int N_RANDOM    = 200;
  localparam int N_TOTAL     = N_SWEEP + N_RANDOM;
  localparam int CYCLE_LIMIT = 20 * N_TOTAL + 200;

  logic   clk = 1'b0;
  logic   rst;
  logic   in_valid;
  fixed_t in_data;
  logic   in_ready;
  logic   out_valid;
  fixed_t out_data;
  logic   out_ready;

  integer seed = 32'h0970_7b56;
  int     cycle_count = 0;
  int     n_in = 0;
  int     n_out = 0;
  int     last_accept = 0;
  int     value_errors = 0;
  int     count_errors = 0;
  int     protocol_errors = 0;
  fixed_t expect_q[$];
  fixed_t stim[$];
  int     idle_gaps[$];
  fixed_t exp_val;
  fixed_t data_prev;
  logic   stall_prev = 1'b0;

  `include "sigmoid_tb_ref.svh"

  always #5 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // consumer readiness, mostly high
  always @(posedge clk) begin
    #1;
    out_ready = ($random(seed) & 3) != 0;
  end

  sigmoid_top u_sigmoid_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  //##########################################################################
  // stimulus
  //##########################################################################

  task automatic flag_protocol(input string msg);
    protocol_errors++;
    $display("protocol violation at %0t ns: %s", $time, msg);
  endtask

  // idle cycles, then hold the beat until it transfers
  task automatic send_sample(input fixed_t value, input int idle);
    logic accepted;
    repeat (idle) begin
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_data  = value;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    // -32, -2.5, -2, -0.25, 0, 0.25, 1.99, 2, 31.99
    stim = '{fixed_t'(-32768), fixed_t'(-2560), fixed_t'(-2048), fixed_t'(-256),
             fixed_t'(0), fixed_t'(256), fixed_t'(2038), fixed_t'(2048), fixed_t'(32758)};
    for (int i = 0; i < N_RANDOM; i++) begin
      stim.push_back(fixed_t'($random(seed)));
    end
    for (int i = 0; i < N_TOTAL; i++) begin
      idle_gaps.push_back($random(seed) & 3);
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (stim[i]) begin
      send_sample(stim[i], idle_gaps[i]);
    end
    wait (n_out == N_TOTAL);
    // a few more cycles to catch stray beats
    repeat (4) @(posedge clk);
    check_count(n_out, n_in, "output beats");
    check_count(expect_q.size(), 0, "pending results");
    $display("errors: value %0d, count %0d, protocol %0d",
             value_errors, count_errors, protocol_errors);
    if (value_errors + count_errors + protocol_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  //##########################################################################
  // scoreboard, sampled mid-cycle where everything is settled
  //##########################################################################

  always @(negedge clk) begin
    if ((rst || n_in == 0) && out_valid !== 1'b0) begin
      flag_protocol("out_valid high before any input was accepted");
    end
    if (!rst) begin
      // stalled beat must stay put until taken
      if (stall_prev) begin
        if (out_valid !== 1'b1) begin
          flag_protocol("out_valid dropped before the stalled beat transferred");
        end else if (out_data !== data_prev) begin
          flag_protocol("out_data changed while the consumer stalled");
        end
      end
      stall_prev = out_valid && !out_ready;
      data_prev  = out_data;
      if (in_valid === 1'b1 && in_ready === 1'b1) begin
        if (n_in > 0 && cycle_count - last_accept < `SIG_OUTPUT_GAP + 1) begin
          flag_protocol("two input beats accepted closer than the output gap");
        end
        last_accept = cycle_count;
        expect_q.push_back(ref_sigmoid(in_data));
        n_in++;
      end
      if (out_valid === 1'b1 && out_ready === 1'b1) begin
        if (expect_q.size() == 0) begin
          flag_protocol("output beat with no input pending");
        end else begin
          exp_val = expect_q.pop_front();
          check_value(out_data, exp_val, "sigmoid output");
        end
        n_out++;
      end
    end
  end

  //##########################################################################
  // timeout
  //##########################################################################

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("run timed out after %0d cycles with %0d of %0d outputs",
             cycle_count, n_out, N_TOTAL);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+source
+incdir+verif
source/sig_fixed_pkg.sv
source/sig_ctrl_pkg.sv
source/sigmoid_layer.sv
source/ap_start_control.sv
source/result_timing.sv
source/output_hold_buffer.sv
source/output_gap_timer.sv
source/sigmoid_top.sv
verif/sigmoid_tb.sv
